// ==== Bender.yml ====
package:
  name: bexkat_mem

sources:
  - bexkat_pkg.sv
  - bus_arbiter_fsm.sv
  - outstanding_counter.sv
  - bus_route.sv
  - wb_ram.sv
  - mem_top.sv
  - target: simulation
    files:
      - tb_mem_top.sv

// ==== bexkat_pkg.sv ====
package bexkat_pkg;

  // Bus word geometry for the fixed 32-bit design
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BYTE_W = 8;
  localparam int unsigned SEL_W  = DATA_W / BYTE_W;

  // One data beat on either master port or the memory side
  typedef logic [DATA_W-1:0] word_t;

  // Byte lane enables where bit i covers bits 8*i+7 down to 8*i
  typedef logic [SEL_W-1:0] sel_t;

  // Owner of the shared memory bus
  typedef enum logic [1:0] {
    GNT_NONE = 2'd0,  // Bus idle, both ports stalled
    GNT_INS  = 2'd1,  // Instruction fetch port
    GNT_DAT  = 2'd2   // Load/store port
  } grant_e;

endpackage

// ==== bus_arbiter_fsm.sv ====
`timescale 1ns/1ps

module bus_arbiter_fsm (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              ins_cyc_i,
  input  logic              dat_cyc_i,
  input  logic              drained_i,
  output bexkat_pkg::grant_e grant_o
);

  import bexkat_pkg::*;

  grant_e state_q;
  grant_e state_d;

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      GNT_NONE:
      begin
        if (dat_cyc_i)
        begin
          state_d = GNT_DAT;  // Data port has priority
        end
        else if (ins_cyc_i)
        begin
          state_d = GNT_INS;
        end
      end
      GNT_INS:
      begin
        if (!ins_cyc_i && drained_i)
        begin
          state_d = GNT_NONE;
        end
      end
      GNT_DAT:
      begin
        if (!dat_cyc_i && drained_i)
        begin
          state_d = GNT_NONE;
        end
      end
      default:
      begin
        state_d = GNT_NONE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= GNT_NONE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  assign grant_o = state_q;

  // Releasing the bus with acks still pending would hand them to the wrong port
  a_hold_until_drained : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !drained_i |=> state_q == $past(state_q)
  ) else $error("arbiter grant changed with responses outstanding");

endmodule

// ==== bus_route.sv ====
`timescale 1ns/1ps

module bus_route #(
  parameter int unsigned ADDR_W = 10
) (
  input  bexkat_pkg::grant_e grant_i,
  // Instruction master
  input  logic               ins_stb_i,
  input  logic [ADDR_W-1:0]  ins_adr_i,
  output logic               ins_stall_o,
  output logic               ins_ack_o,
  output bexkat_pkg::word_t  ins_rdata_o,
  // Data master
  input  logic               dat_stb_i,
  input  logic               dat_we_i,
  input  bexkat_pkg::sel_t   dat_sel_i,
  input  logic [ADDR_W-1:0]  dat_adr_i,
  input  bexkat_pkg::word_t  dat_wdata_i,
  output logic               dat_stall_o,
  output logic               dat_ack_o,
  output bexkat_pkg::word_t  dat_rdata_o,
  // Memory side
  input  logic               mem_ack_i,
  input  bexkat_pkg::word_t  mem_rdata_i,
  output logic               accept_o,
  output logic [ADDR_W-1:0]  mem_adr_o,
  output logic               mem_we_o,
  output bexkat_pkg::sel_t   mem_sel_o,
  output bexkat_pkg::word_t  mem_wdata_o
);

  import bexkat_pkg::*;

  logic ins_gnt;
  logic dat_gnt;

  assign ins_gnt = (grant_i == GNT_INS);
  assign dat_gnt = (grant_i == GNT_DAT);

  // RAM never stalls, so only the grant holds a master off
  assign ins_stall_o = !ins_gnt;
  assign dat_stall_o = !dat_gnt;

  assign accept_o = (ins_gnt && ins_stb_i) || (dat_gnt && dat_stb_i);

  always_comb
  begin
    if (ins_gnt)
    begin
      mem_adr_o   = ins_adr_i;
      mem_we_o    = 1'b0;
      mem_sel_o   = '1;  // Fetches always take the whole word
      mem_wdata_o = '0;
    end
    else
    begin
      mem_adr_o   = dat_adr_i;
      mem_we_o    = dat_gnt && dat_we_i;
      mem_sel_o   = dat_sel_i;
      mem_wdata_o = dat_wdata_i;
    end
  end

  // Responses only go back to the current owner
  assign ins_ack_o   = ins_gnt && mem_ack_i;
  assign dat_ack_o   = dat_gnt && mem_ack_i;
  assign ins_rdata_o = ins_gnt ? mem_rdata_i : '0;
  assign dat_rdata_o = dat_gnt ? mem_rdata_i : '0;

endmodule

// ==== mem_top.sv ====
`timescale 1ns/1ps

module mem_top #(
  parameter int unsigned ADDR_W  = 10,
  parameter int unsigned LATENCY = 2,
  parameter int unsigned CNT_W   = 3
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Instruction master
  input  logic              ins_cyc_i,
  input  logic              ins_stb_i,
  input  logic [ADDR_W-1:0] ins_adr_i,
  output logic              ins_stall_o,
  output logic              ins_ack_o,
  output bexkat_pkg::word_t ins_rdata_o,
  // Data master
  input  logic              dat_cyc_i,
  input  logic              dat_stb_i,
  input  logic              dat_we_i,
  input  bexkat_pkg::sel_t  dat_sel_i,
  input  logic [ADDR_W-1:0] dat_adr_i,
  input  bexkat_pkg::word_t dat_wdata_i,
  output logic              dat_stall_o,
  output logic              dat_ack_o,
  output bexkat_pkg::word_t dat_rdata_o
);

  import bexkat_pkg::*;

  grant_e            grant;
  logic              drained;
  logic              accept;
  logic [ADDR_W-1:0] mem_adr;
  logic              mem_we;
  sel_t              mem_sel;
  word_t             mem_wdata;
  logic              mem_ack;
  word_t             mem_rdata;

  bus_arbiter_fsm arb_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ins_cyc_i (ins_cyc_i),
    .dat_cyc_i (dat_cyc_i),
    .drained_i (drained),
    .grant_o   (grant)
  );

  outstanding_counter #(
    .CNT_W (CNT_W)
  ) cnt_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .accept_i  (accept),
    .ack_i     (mem_ack),
    .drained_o (drained)
  );

  bus_route #(
    .ADDR_W (ADDR_W)
  ) route_inst (
    .grant_i     (grant),
    .ins_stb_i   (ins_stb_i),
    .ins_adr_i   (ins_adr_i),
    .ins_stall_o (ins_stall_o),
    .ins_ack_o   (ins_ack_o),
    .ins_rdata_o (ins_rdata_o),
    .dat_stb_i   (dat_stb_i),
    .dat_we_i    (dat_we_i),
    .dat_sel_i   (dat_sel_i),
    .dat_adr_i   (dat_adr_i),
    .dat_wdata_i (dat_wdata_i),
    .dat_stall_o (dat_stall_o),
    .dat_ack_o   (dat_ack_o),
    .dat_rdata_o (dat_rdata_o),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_rdata),
    .accept_o    (accept),
    .mem_adr_o   (mem_adr),
    .mem_we_o    (mem_we),
    .mem_sel_o   (mem_sel),
    .mem_wdata_o (mem_wdata)
  );

  wb_ram #(
    .ADDR_W  (ADDR_W),
    .LATENCY (LATENCY)
  ) ram_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .accept_i (accept),
    .adr_i    (mem_adr),
    .we_i     (mem_we),
    .sel_i    (mem_sel),
    .wdata_i  (mem_wdata),
    .ack_o    (mem_ack),
    .rdata_o  (mem_rdata)
  );

endmodule

// ==== outstanding_counter.sv ====
`timescale 1ns/1ps

module outstanding_counter #(
  parameter int unsigned CNT_W = 3
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic accept_i,
  input  logic ack_i,
  output logic drained_o
);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      count_q <= '0;
    end
    else
    begin
      case ({accept_i, ack_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle, or one in and one out
      endcase
    end
  end

  // A request entering this cycle is not yet counted
  assign drained_o = (count_q == '0) && !accept_i;

  a_no_spurious_ack : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ack_i |-> count_q != '0
  ) else $error("ack returned with no request outstanding");

  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (accept_i && !ack_i) |-> count_q != '1
  ) else $error("outstanding request counter overflow");

endmodule

// ==== project.f ====
bexkat_pkg.sv
bus_arbiter_fsm.sv
outstanding_counter.sv
bus_route.sv
wb_ram.sv
mem_top.sv
tb_mem_top.sv

// ==== tb_mem_top.sv ====
`timescale 1ns/1ps

module tb_mem_top;

  import bexkat_pkg::*;

  localparam int unsigned ADDR_W  = 10;
  localparam int unsigned LATENCY = 2;
  localparam int unsigned CNT_W   = 3;
  localparam int unsigned DEPTH   = 2 ** ADDR_W;
  localparam int TIMEOUT = 64;
  localparam int BURST_N = 4;

  logic              clk_i;
  logic              rst_n_i;
  logic              ins_cyc_i;
  logic              ins_stb_i;
  logic [ADDR_W-1:0] ins_adr_i;
  logic              ins_stall_o;
  logic              ins_ack_o;
  word_t             ins_rdata_o;
  logic              dat_cyc_i;
  logic              dat_stb_i;
  logic              dat_we_i;
  sel_t              dat_sel_i;
  logic [ADDR_W-1:0] dat_adr_i;
  word_t             dat_wdata_i;
  logic              dat_stall_o;
  logic              dat_ack_o;
  word_t             dat_rdata_o;

  word_t       ref_mem [DEPTH];  // Expected RAM contents
  logic        written [DEPTH];
  logic [15:0] lfsr_q;

  mem_top #(
    .ADDR_W  (ADDR_W),
    .LATENCY (LATENCY),
    .CNT_W   (CNT_W)
  ) mem_top_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ins_cyc_i   (ins_cyc_i),
    .ins_stb_i   (ins_stb_i),
    .ins_adr_i   (ins_adr_i),
    .ins_stall_o (ins_stall_o),
    .ins_ack_o   (ins_ack_o),
    .ins_rdata_o (ins_rdata_o),
    .dat_cyc_i   (dat_cyc_i),
    .dat_stb_i   (dat_stb_i),
    .dat_we_i    (dat_we_i),
    .dat_sel_i   (dat_sel_i),
    .dat_adr_i   (dat_adr_i),
    .dat_wdata_i (dat_wdata_i),
    .dat_stall_o (dat_stall_o),
    .dat_ack_o   (dat_ack_o),
    .dat_rdata_o (dat_rdata_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    stop_run();
  endtask

  task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp)
    begin
      $display("Error: %s got 0x%h expected 0x%h", name, act, exp);
      stop_run();
    end
  endtask

  task automatic check_grant(input string name, input grant_e act, input grant_e exp);
    if (act !== exp)
    begin
      $display("Error: %s got 0x%h expected 0x%h", name, act, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("Error: %s got 0x%h expected 0x%h", name, act, exp);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int act, input int exp);
    if (act != exp)
    begin
      $display("Error: %s got 0x%0h expected 0x%0h", name, act, exp);
      stop_run();
    end
  endtask

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // Single data-port access that counts edges from the one that raises stb
  task automatic dat_access(input logic we, input sel_t sel, input logic [ADDR_W-1:0] adr,
                            input word_t wdata, output word_t rdata, output int edges);
    int   wait_n;
    logic done;
    edges = 0;
    wait_n = 0;
    done = 1'b0;
    rdata = '0;
    @(posedge clk_i);
    dat_cyc_i   <= 1'b1;
    dat_stb_i   <= 1'b1;
    dat_we_i    <= we;
    dat_sel_i   <= sel;
    dat_adr_i   <= adr;
    dat_wdata_i <= wdata;
    while (!done)
    begin
      @(posedge clk_i);
      edges++;
      wait_n++;
      check_bit("dat_ack_o", dat_ack_o, 1'b0);
      if (!dat_stall_o)
        done = 1'b1;
      else if (wait_n >= TIMEOUT)
        timeout_fail("dat_stall_o to drop");
    end
    dat_stb_i <= 1'b0;
    dat_we_i  <= 1'b0;
    done = 1'b0;
    wait_n = 0;
    while (!done)
    begin
      @(posedge clk_i);
      edges++;
      wait_n++;
      if (dat_ack_o)
      begin
        done = 1'b1;
        rdata = dat_rdata_o;
      end
      else if (wait_n >= TIMEOUT)
        timeout_fail("dat_ack_o");
    end
    dat_cyc_i <= 1'b0;
  endtask

  task automatic dat_write(input logic [ADDR_W-1:0] adr, input word_t wdata, input sel_t sel);
    word_t rdata;
    int    edges;
    dat_access(1'b1, sel, adr, wdata, rdata, edges);
    for (int b = 0; b < 4; b++)
    begin
      if (sel[b])
        ref_mem[adr][8*b +: 8] = wdata[8*b +: 8];
    end
    written[adr] = 1'b1;
  endtask

  task automatic dat_read(input logic [ADDR_W-1:0] adr, output int edges);
    word_t rdata;
    dat_access(1'b0, 4'hF, adr, '0, rdata, edges);
    check_word("dat_rdata_o", rdata, ref_mem[adr]);
  endtask

  task automatic ins_read(input logic [ADDR_W-1:0] adr, output int edges, output realtime acc_t);
    int    wait_n;
    logic  done;
    word_t rdata;
    edges = 0;
    wait_n = 0;
    done = 1'b0;
    rdata = '0;
    acc_t = 0;
    @(posedge clk_i);
    ins_cyc_i <= 1'b1;
    ins_stb_i <= 1'b1;
    ins_adr_i <= adr;
    while (!done)
    begin
      @(posedge clk_i);
      edges++;
      wait_n++;
      check_bit("ins_ack_o", ins_ack_o, 1'b0);
      if (!ins_stall_o)
      begin
        done = 1'b1;
        acc_t = $realtime;
      end
      else if (wait_n >= TIMEOUT)
        timeout_fail("ins_stall_o to drop");
    end
    ins_stb_i <= 1'b0;
    done = 1'b0;
    wait_n = 0;
    while (!done)
    begin
      @(posedge clk_i);
      edges++;
      wait_n++;
      if (ins_ack_o)
      begin
        done = 1'b1;
        rdata = ins_rdata_o;
      end
      else if (wait_n >= TIMEOUT)
        timeout_fail("ins_ack_o");
    end
    ins_cyc_i <= 1'b0;
    check_word("ins_rdata_o", rdata, ref_mem[adr]);
  endtask

  // Back-to-back reads on one cyc whose acks must come back in issue order
  task automatic dat_read_burst(input logic [ADDR_W-1:0] adrs [BURST_N],
                                output int first_acc, output realtime last_ack_t);
    int issued;
    int acked;
    int edges;
    int last_acc;
    issued = 0;
    acked = 0;
    edges = 0;
    first_acc = 0;
    last_acc = 0;
    last_ack_t = 0;
    @(posedge clk_i);
    dat_cyc_i <= 1'b1;
    dat_stb_i <= 1'b1;
    dat_we_i  <= 1'b0;
    dat_sel_i <= 4'hF;
    dat_adr_i <= adrs[0];
    while (acked < BURST_N)
    begin
      @(posedge clk_i);
      edges++;
      if (dat_ack_o)
      begin
        if (acked >= issued)
        begin
          $display("Data port ack arrived with no request outstanding");
          stop_run();
        end
        check_word("dat_rdata_o", dat_rdata_o, ref_mem[adrs[acked]]);
        acked++;
        last_ack_t = $realtime;
      end
      if (dat_stb_i && !dat_stall_o)
      begin
        if (issued == 0)
          first_acc = edges;
        last_acc = edges;
        issued++;
        if (issued < BURST_N)
          dat_adr_i <= adrs[issued];
        else
          dat_stb_i <= 1'b0;
      end
      if (edges >= TIMEOUT)
        timeout_fail("burst acks on the data port");
    end
    dat_cyc_i <= 1'b0;
    check_count("burst issue span", last_acc - first_acc, BURST_N - 1);
  endtask

  task automatic test_reset();
    repeat (3)
    begin
      @(posedge clk_i);
      check_grant("grant", mem_top_inst.grant, GNT_NONE);
      check_bit("ins_stall_o", ins_stall_o, 1'b1);
      check_bit("dat_stall_o", dat_stall_o, 1'b1);
      check_bit("ins_ack_o", ins_ack_o, 1'b0);
      check_bit("dat_ack_o", dat_ack_o, 1'b0);
    end
  endtask

  task automatic test_write_read();
    logic [ADDR_W-1:0] adr;
    int                edges;
    adr = rand_bits(ADDR_W);
    dat_write(adr, rand_bits(32), 4'hF);
    dat_read(adr, edges);
    check_count("dat_ack_o latency", edges - 1, 1 + LATENCY);  // From the edge that grants
  endtask

  task automatic test_partial_write();
    logic [ADDR_W-1:0] adr;
    word_t             old_w;
    word_t             new_w;
    int                edges;
    adr = rand_bits(ADDR_W);
    old_w = rand_bits(32);
    new_w = rand_bits(32);
    dat_write(adr, old_w, 4'hF);
    dat_write(adr, new_w, 4'b0101);
    check_word("merged word", ref_mem[adr],
               {old_w[31:24], new_w[23:16], old_w[15:8], new_w[7:0]});
    dat_read(adr, edges);
  endtask

  task automatic test_ins_read();
    logic [ADDR_W-1:0] adr;
    int                edges;
    realtime           acc_t;
    adr = rand_bits(ADDR_W);
    dat_write(adr, rand_bits(32), 4'hF);
    ins_read(adr, edges, acc_t);
    check_count("ins_ack_o latency", edges - 1, 1 + LATENCY);
  endtask

  task automatic test_burst();
    logic [ADDR_W-1:0] adrs [BURST_N];
    logic [ADDR_W-1:0] base;
    int                first_acc;
    realtime           last_t;
    base = rand_bits(ADDR_W);
    for (int i = 0; i < BURST_N; i++)
    begin
      adrs[i] = base + i;
      dat_write(adrs[i], rand_bits(32), 4'hF);
    end
    dat_read_burst(adrs, first_acc, last_t);
  endtask

  task automatic test_arbitration();
    logic [ADDR_W-1:0] adrs [BURST_N];
    logic [ADDR_W-1:0] iadr;
    int                first_acc;
    int                edges;
    realtime           dat_done_t;
    realtime           ins_acc_t;
    for (int i = 0; i < BURST_N; i++)
    begin
      adrs[i] = rand_bits(ADDR_W);
      dat_write(adrs[i], rand_bits(32), 4'hF);
    end
    iadr = rand_bits(ADDR_W);
    dat_write(iadr, rand_bits(32), 4'hF);
    fork
      dat_read_burst(adrs, first_acc, dat_done_t);
      ins_read(iadr, edges, ins_acc_t);
    join
    check_count("dat first accept edge", first_acc, 2);  // Data port won the tie
    if (ins_acc_t <= dat_done_t)
    begin
      $display("Instruction port was accepted before the data port drained");
      stop_run();
    end
  endtask

  task automatic test_random();
    logic [ADDR_W-1:0] adr;
    sel_t              sel;
    int                edges;
    realtime           acc_t;
    for (int i = 0; i < 64; i++)
    begin
      adr = rand_bits(ADDR_W);
      sel = written[adr] ? sel_t'(rand_bits(4)) : 4'hF;  // No X bytes in fresh words
      dat_write(adr, rand_bits(32), sel);
      if (i % 2 == 0)
        dat_read(adr, edges);
      else
        ins_read(adr, edges, acc_t);
    end
  endtask

  initial
  begin
    lfsr_q = 16'd78;
    rst_n_i = 1'b0;
    ins_cyc_i = 1'b0;
    ins_stb_i = 1'b0;
    ins_adr_i = '0;
    dat_cyc_i = 1'b0;
    dat_stb_i = 1'b0;
    dat_we_i = 1'b0;
    dat_sel_i = '0;
    dat_adr_i = '0;
    dat_wdata_i = '0;
    for (int a = 0; a < DEPTH; a++)
    begin
      ref_mem[a] = '0;
      written[a] = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset();
    test_write_read();
    test_partial_write();
    test_ins_read();
    test_burst();
    test_arbitration();
    test_random();
    repeat (2) @(posedge clk_i);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram #(
  parameter int unsigned ADDR_W  = 10,
  parameter int unsigned LATENCY = 2
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              accept_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic              we_i,
  input  bexkat_pkg::sel_t  sel_i,
  input  bexkat_pkg::word_t wdata_i,
  output logic              ack_o,
  output bexkat_pkg::word_t rdata_o
);

  import bexkat_pkg::*;

  localparam int unsigned DEPTH = 2 ** ADDR_W;

  word_t              mem_q [DEPTH];
  logic [LATENCY-1:0] vld_q;        // Response valid per pipeline stage
  word_t              dat_q [LATENCY];

  // Byte-lane writes land at the accepting edge
  always_ff @(posedge clk_i)
  begin
    if (accept_i && we_i)
    begin
      for (int b = 0; b < SEL_W; b++)
      begin
        if (sel_i[b])
        begin
          mem_q[adr_i][b*BYTE_W +: BYTE_W] <= wdata_i[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // Read word follows the valid bit down the pipe
  always_ff @(posedge clk_i)
  begin
    dat_q[0] <= mem_q[adr_i];
    for (int i = 1; i < LATENCY; i++)
    begin
      dat_q[i] <= dat_q[i-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      vld_q <= '0;
    end
    else
    begin
      vld_q[0] <= accept_i;
      for (int i = 1; i < LATENCY; i++)
      begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  assign ack_o   = vld_q[LATENCY-1];
  assign rdata_o = dat_q[LATENCY-1];

endmodule
